//--- files.f
+incdir+rtl
rtl/axil_apb_pkg.sv
rtl/axil_pause_gate.sv
rtl/apb_addr_decode.sv
rtl/axil_to_apb_core.sv
rtl/axil_apb_bridge.sv
testbench/apb_completer_model.sv
testbench/tb_axil_apb_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_axil_apb_bridge -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- testbench/tb_axil_apb_bridge.sv
`default_nettype none

`include "axil_apb_consts.svh"

module tb_axil_apb_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    import axil_apb_pkg::*;

    localparam int    tmo_cycles = 64;
    localparam addr_t win_size   = 32'h100;
    localparam addr_t err_offset = 32'h80;
    localparam resp_t okay_rsp   = 2'b00;
    localparam resp_t slverr_rsp = 2'b10;

    logic  clk, arst_n, pause_req, pause_ack;
    logic  s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic  s_arvalid, s_arready, s_rvalid, s_rready;
    addr_t s_awaddr, s_araddr;
    prot_t s_awprot, s_arprot;
    data_t s_wdata, s_rdata;
    strb_t s_wstrb;
    resp_t s_bresp, s_rresp;
    addr_t map_start [`APB_NUM_SLAVES];
    addr_t map_end   [`APB_NUM_SLAVES];
    addr_t paddr     [`APB_NUM_SLAVES];
    data_t prdata    [`APB_NUM_SLAVES];
    sel_t  psel, pready, pslverr;
    logic  penable, pwrite;
    data_t pwdata;
    strb_t pstrb;
    prot_t pprot;
    logic [1:0] wait_cyc;

    logic [31:0] lfsr;
    int          errs, err_total, test_cnt, fail_cnt;
    sel_t        seen_any;   // Every psel bit seen during a transaction.
    sel_t        acc_sel;
    addr_t       acc_addr;
    data_t       acc_wdata;
    strb_t       acc_strb;
    logic        acc_write;
    prot_t       acc_prot;

    axil_apb_bridge UUT (
        .clk       (clk),       .arst_n    (arst_n),
        .pause_req (pause_req), .pause_ack (pause_ack),
        .s_awvalid (s_awvalid), .s_awready (s_awready),
        .s_awaddr  (s_awaddr),  .s_awprot  (s_awprot),
        .s_wvalid  (s_wvalid),  .s_wready  (s_wready),
        .s_wdata   (s_wdata),   .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),  .s_bready  (s_bready),  .s_bresp (s_bresp),
        .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_araddr  (s_araddr),  .s_arprot  (s_arprot),
        .s_rvalid  (s_rvalid),  .s_rready  (s_rready),
        .s_rdata   (s_rdata),   .s_rresp   (s_rresp),
        .map_start (map_start), .map_end   (map_end),
        .psel      (psel),      .paddr     (paddr),     .penable (penable),
        .pwrite    (pwrite),    .pwdata    (pwdata),    .pstrb   (pstrb),
        .pprot     (pprot),     .pready    (pready),    .prdata  (prdata),
        .pslverr   (pslverr)
    );

    apb_completer_model u_completers (
        .clk         (clk),     .arst_n  (arst_n),
        .psel        (psel),    .paddr   (paddr),   .penable (penable),
        .pwrite      (pwrite),  .pwdata  (pwdata),  .pstrb   (pstrb),
        .wait_cycles (wait_cyc),
        .pready      (pready),  .prdata  (prdata),  .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic addr_t win_start(input int i);
        return addr_t'(32'h1000 * (i + 1));
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 'h%0h, expected 'h%0h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errs++;
        end
    endtask

    // Expected select, offset and response from the window rules.
    task automatic expect_for(input addr_t addr, output sel_t sel, output addr_t off,
                              output resp_t resp);
        logic hit;
        sel  = '0;
        off  = '0;
        resp = slverr_rsp;
        hit  = 1'b0;
        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            if (!hit && addr >= win_start(i) && addr < win_start(i) + win_size) begin
                hit    = 1'b1;
                sel[i] = 1'b1;
                off    = addr - win_start(i);
                resp   = (off >= err_offset) ? slverr_rsp : okay_rsp;
            end
        end
    endtask

    task automatic watch_apb();
        seen_any = seen_any | psel;
        check_true($onehot0(psel), "psel is not one-hot");
        if (penable && (psel != '0)) begin
            acc_sel   = psel;
            acc_wdata = pwdata;
            acc_strb  = pstrb;
            acc_write = pwrite;
            acc_prot  = pprot;
            for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
                if (psel[i]) acc_addr = paddr[i];
            end
        end
    endtask

    task automatic drive_write(input addr_t addr, input data_t data, input strb_t strb,
                               input prot_t prot);
        s_awvalid <= 1'b1;
        s_awaddr  <= addr;
        s_awprot  <= prot;
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= strb;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI-Lite driver, entered and left just after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_write(input addr_t addr, input data_t data, input strb_t strb,
                              input prot_t prot);
        int n;
        drive_write(addr, data, strb, prot);
        wait_cyc <= 2'(rand_bits(2));
        seen_any = '0;
        acc_sel  = '0;
        n = 0;
        do begin
            @(negedge clk);
            watch_apb();
            n++;
        end while (!(s_awready && s_wready) && n < tmo_cycles);
        check_true(s_awready && s_wready, "timeout waiting for awready and wready");
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
    endtask

    task automatic send_read(input addr_t addr, input prot_t prot);
        int n;
        s_arvalid <= 1'b1;
        s_araddr  <= addr;
        s_arprot  <= prot;
        wait_cyc  <= 2'(rand_bits(2));
        seen_any = '0;
        acc_sel  = '0;
        n = 0;
        do begin
            @(negedge clk);
            watch_apb();
            n++;
        end while (!s_arready && n < tmo_cycles);
        check_true(s_arready, "timeout waiting for arready");
        @(posedge clk);
        s_arvalid <= 1'b0;
    endtask

    // Waits for B or R, holding ready low for hold cycles after valid rises.
    task automatic take_resp(input logic is_wr, input int hold, output resp_t resp,
                             output data_t data);
        int n;
        if (is_wr) s_bready <= (hold == 0);
        else s_rready <= (hold == 0);
        n = 0;
        do begin
            @(negedge clk);
            watch_apb();
            n++;
        end while (!(is_wr ? s_bvalid : s_rvalid) && n < tmo_cycles);
        check_true(is_wr ? s_bvalid : s_rvalid, "timeout waiting for the response");
        resp = is_wr ? s_bresp : s_rresp;
        data = s_rdata;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            if (is_wr) begin
                check_eq("bvalid", s_bvalid, 1);
                check_eq("bresp", s_bresp, resp);
            end else begin
                check_eq("rvalid", s_rvalid, 1);
                check_eq("rresp", s_rresp, resp);
                check_eq("rdata", s_rdata, data);
            end
            check_true(!s_awready && !s_arready, "request accepted before the response handshake");
        end
        if (hold > 0) begin
            @(posedge clk);
            if (is_wr) s_bready <= 1'b1;
            else s_rready <= 1'b1;
        end
        @(posedge clk);
        s_bready <= 1'b0;
        s_rready <= 1'b0;
    endtask

    task automatic check_apb(input sel_t e_sel, input addr_t e_off, input logic wr,
                             input prot_t prot);
        if (e_sel == '0) begin
            check_eq("psel", seen_any, 0);   // A miss never reaches APB.
        end else begin
            check_eq("psel", acc_sel, e_sel);
            check_eq("paddr", acc_addr, e_off);
            check_eq("pwrite", acc_write, wr);
            check_eq("pprot", acc_prot, prot);
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data, input strb_t strb,
                            input prot_t prot, input int hold);
        sel_t  e_sel;
        addr_t e_off;
        resp_t e_resp;
        resp_t resp;
        data_t rd;
        expect_for(addr, e_sel, e_off, e_resp);
        send_write(addr, data, strb, prot);
        take_resp(1'b1, hold, resp, rd);
        check_eq("bresp", resp, e_resp);
        check_apb(e_sel, e_off, 1'b1, prot);
        if (e_sel != '0) begin
            check_eq("pwdata", acc_wdata, data);
            check_eq("pstrb", acc_strb, strb);
        end
    endtask

    task automatic do_read(input addr_t addr, input prot_t prot, input int hold,
                           input data_t exp_data);
        sel_t  e_sel;
        addr_t e_off;
        resp_t e_resp;
        resp_t resp;
        data_t rd;
        expect_for(addr, e_sel, e_off, e_resp);
        send_read(addr, prot);
        take_resp(1'b0, hold, resp, rd);
        check_eq("rresp", resp, e_resp);
        check_apb(e_sel, e_off, 1'b0, prot);
        if (e_resp == okay_rsp) check_eq("rdata", rd, exp_data);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, errs);
            fail_cnt++;
        end
        err_total += errs;
        errs = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        addr_t a;
        data_t d;
        prot_t p;
        resp_t r;
        data_t q;
        int    n;
        lfsr      = 32'h46c04ab9;
        errs      = 0;
        err_total = 0;
        test_cnt  = 0;
        fail_cnt  = 0;
        arst_n    <= 1'b0;
        pause_req <= 1'b0;
        s_awvalid <= 1'b0;
        s_awaddr  <= '0;
        s_awprot  <= '0;
        s_wvalid  <= 1'b0;
        s_wdata   <= '0;
        s_wstrb   <= '0;
        s_bready  <= 1'b0;
        s_arvalid <= 1'b0;
        s_araddr  <= '0;
        s_arprot  <= '0;
        s_rready  <= 1'b0;
        wait_cyc  <= '0;
        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            map_start[i] <= win_start(i);
            map_end[i]   <= win_start(i) + win_size;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_eq("reset outputs", {s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
                                   penable, pause_ack, psel}, 0);
        @(posedge clk);
        arst_n <= 1'b1;   // Released after 8 cycles.
        @(posedge clk);
        finish_test("reset");

        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            a = win_start(i) + (rand_bits(5) << 2);
            do_write(a, rand_bits(32), strb_t'(rand_bits(4)), prot_t'(rand_bits(3)), 0);
        end
        finish_test("window writes");

        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            a = win_start(i) + (rand_bits(5) << 2);
            d = rand_bits(32);
            p = prot_t'(rand_bits(3));
            do_write(a, d, 4'hf, p, 0);
            do_read(a, p, 0, d);
        end
        finish_test("read after write");

        do_write(32'h1100, rand_bits(32), 4'hf, 3'd0, 0);   // End address is exclusive.
        do_read(32'h3000 + (rand_bits(8) << 2), 3'd0, 0, '0);
        finish_test("unmapped address");

        a = win_start(1) + err_offset + (rand_bits(5) << 2);
        do_write(a, rand_bits(32), 4'hf, 3'd2, 0);
        do_read(a, 3'd2, 0, '0);
        finish_test("slave error");

        pause_req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pause_ack && n < tmo_cycles);
        check_true(pause_ack, "timeout waiting for pause_ack");
        @(posedge clk);
        a = win_start(0) + (rand_bits(5) << 2);
        d = rand_bits(32);
        drive_write(a, d, 4'hf, 3'd1);
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            check_true(!s_awready && !s_wready && psel == '0, "write accepted while paused");
        end
        @(posedge clk);
        pause_req <= 1'b0;
        do_write(a, d, 4'hf, 3'd1, 0);   // The held request goes through.
        @(negedge clk);
        check_eq("pause_ack", pause_ack, 0);
        @(posedge clk);
        do_read(a, 3'd1, 0, d);
        finish_test("pause");

        a = win_start(1) + (rand_bits(5) << 2);
        d = rand_bits(32);
        send_write(a, d, 4'hf, 3'd0);
        s_arvalid <= 1'b1;   // Pending read must wait for the B handshake.
        s_araddr  <= a;
        s_arprot  <= 3'd0;
        take_resp(1'b1, 1 + int'(rand_bits(3)), r, q);
        check_eq("bresp", r, okay_rsp);
        send_read(a, 3'd0);
        drive_write(a, ~d, 4'hf, 3'd0);   // Pending write must wait for the R handshake.
        take_resp(1'b0, 1 + int'(rand_bits(3)), r, q);
        check_eq("rresp", r, okay_rsp);
        check_eq("rdata", q, d);
        do_write(a, ~d, 4'hf, 3'd0, 0);
        finish_test("back-pressure");

        $display("tests: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_total);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/apb_completer_model.sv
`default_nettype none

`include "axil_apb_consts.svh"

module apb_completer_model (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  axil_apb_pkg::sel_t       psel,
    input  axil_apb_pkg::addr_t      paddr [`APB_NUM_SLAVES],
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  axil_apb_pkg::data_t      pwdata,
    input  axil_apb_pkg::strb_t      pstrb,
    input  wire logic [1:0]          wait_cycles,
    output axil_apb_pkg::sel_t       pready,
    output axil_apb_pkg::data_t      prdata [`APB_NUM_SLAVES],
    output axil_apb_pkg::sel_t       pslverr
);

    timeunit 1ns;
    timeprecision 1ps;

    import axil_apb_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One completer per window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < `APB_NUM_SLAVES; i++) begin : g_slave
        data_t      mem [64];   // Word memory for offsets 'h00 to 'hfc.
        logic [1:0] wait_cnt;

        assign pready[i]  = psel[i] & penable & (wait_cnt >= wait_cycles);
        assign pslverr[i] = pready[i] & (paddr[i] >= 32'h80);   // Upper half is an error area.
        assign prdata[i]  = mem[paddr[i][7:2]];

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wait_cnt <= '0;
            end else if (psel[i] && penable && !pready[i]) begin
                wait_cnt <= wait_cnt + 2'd1;   // Stretch the access phase.
            end else begin
                wait_cnt <= '0;
            end
        end

        always_ff @(posedge clk) begin
            if (pready[i] && pwrite && !pslverr[i]) begin
                for (int b = 0; b < `AXIL_DATA_WIDTH / 8; b++) begin
                    if (pstrb[b]) mem[paddr[i][7:2]][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/axil_apb_bridge.sv
`default_nettype none

`include "axil_apb_consts.svh"

module axil_apb_bridge (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                pause_req,
    output logic                     pause_ack,
    // AXI-Lite slave port.
    input  wire logic                s_awvalid,
    output logic                     s_awready,
    input  axil_apb_pkg::addr_t      s_awaddr,
    input  axil_apb_pkg::prot_t      s_awprot,
    input  wire logic                s_wvalid,
    output logic                     s_wready,
    input  axil_apb_pkg::data_t      s_wdata,
    input  axil_apb_pkg::strb_t      s_wstrb,
    output logic                     s_bvalid,
    input  wire logic                s_bready,
    output axil_apb_pkg::resp_t      s_bresp,
    input  wire logic                s_arvalid,
    output logic                     s_arready,
    input  axil_apb_pkg::addr_t      s_araddr,
    input  axil_apb_pkg::prot_t      s_arprot,
    output logic                     s_rvalid,
    input  wire logic                s_rready,
    output axil_apb_pkg::data_t      s_rdata,
    output axil_apb_pkg::resp_t      s_rresp,
    // Address windows, end exclusive.
    input  axil_apb_pkg::addr_t      map_start [`APB_NUM_SLAVES],
    input  axil_apb_pkg::addr_t      map_end   [`APB_NUM_SLAVES],
    // APB requester.
    output axil_apb_pkg::sel_t       psel,
    output axil_apb_pkg::addr_t      paddr [`APB_NUM_SLAVES],
    output logic                     penable,
    output logic                     pwrite,
    output axil_apb_pkg::data_t      pwdata,
    output axil_apb_pkg::strb_t      pstrb,
    output axil_apb_pkg::prot_t      pprot,
    input  axil_apb_pkg::sel_t       pready,
    input  axil_apb_pkg::data_t      prdata [`APB_NUM_SLAVES],
    input  axil_apb_pkg::sel_t       pslverr
);

    import axil_apb_pkg::*;

    logic  g_awvalid, g_awready, g_wvalid, g_wready, g_bvalid, g_bready;
    logic  g_arvalid, g_arready, g_rvalid, g_rready;
    addr_t g_awaddr, g_araddr;
    prot_t g_awprot, g_arprot;
    data_t g_wdata, g_rdata;
    strb_t g_wstrb;
    resp_t g_bresp, g_rresp;

    addr_t dec_addr;
    addr_t dec_offset;
    sel_t  dec_sel;
    logic  dec_miss;

    axil_pause_gate u_pause_gate (
        .clk       (clk),
        .arst_n    (arst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .s_awvalid (s_awvalid), .s_awready (s_awready),
        .s_awaddr  (s_awaddr),  .s_awprot  (s_awprot),
        .s_wvalid  (s_wvalid),  .s_wready  (s_wready),
        .s_wdata   (s_wdata),   .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),  .s_bready  (s_bready),  .s_bresp (s_bresp),
        .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_araddr  (s_araddr),  .s_arprot  (s_arprot),
        .s_rvalid  (s_rvalid),  .s_rready  (s_rready),
        .s_rdata   (s_rdata),   .s_rresp   (s_rresp),
        .g_awvalid (g_awvalid), .g_awready (g_awready),
        .g_awaddr  (g_awaddr),  .g_awprot  (g_awprot),
        .g_wvalid  (g_wvalid),  .g_wready  (g_wready),
        .g_wdata   (g_wdata),   .g_wstrb   (g_wstrb),
        .g_bvalid  (g_bvalid),  .g_bready  (g_bready),  .g_bresp (g_bresp),
        .g_arvalid (g_arvalid), .g_arready (g_arready),
        .g_araddr  (g_araddr),  .g_arprot  (g_arprot),
        .g_rvalid  (g_rvalid),  .g_rready  (g_rready),
        .g_rdata   (g_rdata),   .g_rresp   (g_rresp)
    );

    axil_to_apb_core u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .g_awvalid  (g_awvalid), .g_awready (g_awready),
        .g_awaddr   (g_awaddr),  .g_awprot  (g_awprot),
        .g_wvalid   (g_wvalid),  .g_wready  (g_wready),
        .g_wdata    (g_wdata),   .g_wstrb   (g_wstrb),
        .g_bvalid   (g_bvalid),  .g_bready  (g_bready),  .g_bresp (g_bresp),
        .g_arvalid  (g_arvalid), .g_arready (g_arready),
        .g_araddr   (g_araddr),  .g_arprot  (g_arprot),
        .g_rvalid   (g_rvalid),  .g_rready  (g_rready),
        .g_rdata    (g_rdata),   .g_rresp   (g_rresp),
        .dec_addr   (dec_addr),
        .dec_sel    (dec_sel),
        .dec_miss   (dec_miss),
        .dec_offset (dec_offset),
        .psel       (psel),
        .paddr      (paddr),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pprot      (pprot),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr)
    );

    apb_addr_decode u_decode (
        .addr        (dec_addr),
        .map_start   (map_start),
        .map_end     (map_end),
        .sel         (dec_sel),
        .miss        (dec_miss),
        .offset_addr (dec_offset)
    );

endmodule

`default_nettype wire

//--- rtl/axil_to_apb_core.sv
`default_nettype none

`include "axil_apb_consts.svh"

module axil_to_apb_core (
    input  wire logic                clk,
    input  wire logic                arst_n,
    // AXI-Lite port from the pause gate.
    input  wire logic                g_awvalid,
    output logic                     g_awready,
    input  axil_apb_pkg::addr_t      g_awaddr,
    input  axil_apb_pkg::prot_t      g_awprot,
    input  wire logic                g_wvalid,
    output logic                     g_wready,
    input  axil_apb_pkg::data_t      g_wdata,
    input  axil_apb_pkg::strb_t      g_wstrb,
    output logic                     g_bvalid,
    input  wire logic                g_bready,
    output axil_apb_pkg::resp_t      g_bresp,
    input  wire logic                g_arvalid,
    output logic                     g_arready,
    input  axil_apb_pkg::addr_t      g_araddr,
    input  axil_apb_pkg::prot_t      g_arprot,
    output logic                     g_rvalid,
    input  wire logic                g_rready,
    output axil_apb_pkg::data_t      g_rdata,
    output axil_apb_pkg::resp_t      g_rresp,
    // Address decoder.
    output axil_apb_pkg::addr_t      dec_addr,
    input  axil_apb_pkg::sel_t       dec_sel,
    input  wire logic                dec_miss,
    input  axil_apb_pkg::addr_t      dec_offset,
    // APB requester.
    output axil_apb_pkg::sel_t       psel,
    output axil_apb_pkg::addr_t      paddr [`APB_NUM_SLAVES],
    output logic                     penable,
    output logic                     pwrite,
    output axil_apb_pkg::data_t      pwdata,
    output axil_apb_pkg::strb_t      pstrb,
    output axil_apb_pkg::prot_t      pprot,
    input  axil_apb_pkg::sel_t       pready,
    input  axil_apb_pkg::data_t      prdata [`APB_NUM_SLAVES],
    input  axil_apb_pkg::sel_t       pslverr
);

    import axil_apb_pkg::*;

    core_state_t state;
    logic        prefer_rd;   // Read goes first on the next tie.
    logic        grant_wr;
    logic        grant_rd;
    logic        wr_pend;
    logic        rd_pend;
    logic        sel_ready;
    logic        sel_err;
    data_t       sel_rdata;

    addr_t addr_q;
    data_t wdata_q;
    strb_t strb_q;
    prot_t prot_q;
    resp_t resp_q;
    data_t rdata_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign wr_pend  = g_awvalid & g_wvalid;   // AW and W are taken together.
    assign rd_pend  = g_arvalid;
    assign grant_wr = (state == st_idle) & wr_pend & (~rd_pend | ~prefer_rd);
    assign grant_rd = (state == st_idle) & rd_pend & (~wr_pend | prefer_rd);

    assign g_awready = grant_wr;
    assign g_wready  = grant_wr;
    assign g_arready = grant_rd;

    // Decode the incoming address while idle so a miss is known at the handshake.
    assign dec_addr = (state != st_idle) ? addr_q : (grant_wr ? g_awaddr : g_araddr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Completer return mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_ready = |(pready & dec_sel);
    assign sel_err   = |(pslverr & dec_sel);

    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            if (dec_sel[i]) sel_rdata = prdata[i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            prefer_rd <= 1'b0;
            pwrite    <= 1'b0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (grant_wr || grant_rd) begin
                        prefer_rd <= grant_wr;   // Alternate on contention.
                        pwrite    <= grant_wr;
                        if (dec_miss) begin
                            state <= grant_wr ? st_resp_write : st_resp_read;   // Skip APB.
                        end else begin
                            state <= st_setup;
                        end
                    end
                end
                st_setup:  state <= st_access;
                st_access: begin
                    if (sel_ready) state <= pwrite ? st_resp_write : st_resp_read;
                end
                st_resp_write: begin
                    if (g_bready) state <= st_idle;
                end
                st_resp_read: begin
                    if (g_rready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and response payload.
    always_ff @(posedge clk) begin
        if (grant_wr) begin
            addr_q  <= g_awaddr;
            prot_q  <= g_awprot;
            wdata_q <= g_wdata;
            strb_q  <= g_wstrb;
        end else if (grant_rd) begin
            addr_q <= g_araddr;
            prot_q <= g_arprot;
            strb_q <= '0;   // APB reads carry no strobes.
        end
        if ((grant_wr || grant_rd) && dec_miss) begin
            resp_q  <= resp_slverr;
            rdata_q <= '0;
        end else if ((state == st_access) && sel_ready) begin
            resp_q  <= sel_err ? resp_slverr : resp_okay;
            rdata_q <= sel_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign psel    = ((state == st_setup) || (state == st_access)) ? dec_sel : '0;
    assign penable = (state == st_access);
    assign pwdata  = wdata_q;
    assign pstrb   = strb_q;
    assign pprot   = prot_q;   // Protection passes through untouched.

    for (genvar i = 0; i < `APB_NUM_SLAVES; i++) begin : g_paddr
        assign paddr[i] = dec_offset;
    end

    assign g_bvalid = (state == st_resp_write);
    assign g_bresp  = resp_q;
    assign g_rvalid = (state == st_resp_read);
    assign g_rdata  = rdata_q;
    assign g_rresp  = resp_q;

endmodule

`default_nettype wire

//--- rtl/apb_addr_decode.sv
`default_nettype none

`include "axil_apb_consts.svh"

module apb_addr_decode (
    input  axil_apb_pkg::addr_t addr,
    input  axil_apb_pkg::addr_t map_start [`APB_NUM_SLAVES],
    input  axil_apb_pkg::addr_t map_end   [`APB_NUM_SLAVES],
    output axil_apb_pkg::sel_t  sel,
    output logic                miss,
    output axil_apb_pkg::addr_t offset_addr
);

    // Scan from the top so the lowest matching window wins.
    always_comb begin
        sel         = '0;
        miss        = 1'b1;
        offset_addr = addr;
        for (int i = `APB_NUM_SLAVES - 1; i >= 0; i--) begin
            if ((addr >= map_start[i]) && (addr < map_end[i])) begin   // End is exclusive.
                sel         = '0;
                sel[i]      = 1'b1;
                miss        = 1'b0;
                offset_addr = addr - map_start[i];   // Window relative address.
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/axil_pause_gate.sv
`default_nettype none

`include "axil_apb_consts.svh"

module axil_pause_gate (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                pause_req,
    output logic                     pause_ack,
    // Outside AXI-Lite port.
    input  wire logic                s_awvalid,
    output logic                     s_awready,
    input  axil_apb_pkg::addr_t      s_awaddr,
    input  axil_apb_pkg::prot_t      s_awprot,
    input  wire logic                s_wvalid,
    output logic                     s_wready,
    input  axil_apb_pkg::data_t      s_wdata,
    input  axil_apb_pkg::strb_t      s_wstrb,
    output logic                     s_bvalid,
    input  wire logic                s_bready,
    output axil_apb_pkg::resp_t      s_bresp,
    input  wire logic                s_arvalid,
    output logic                     s_arready,
    input  axil_apb_pkg::addr_t      s_araddr,
    input  axil_apb_pkg::prot_t      s_arprot,
    output logic                     s_rvalid,
    input  wire logic                s_rready,
    output axil_apb_pkg::data_t      s_rdata,
    output axil_apb_pkg::resp_t      s_rresp,
    // Gated port towards the core.
    output logic                     g_awvalid,
    input  wire logic                g_awready,
    output axil_apb_pkg::addr_t      g_awaddr,
    output axil_apb_pkg::prot_t      g_awprot,
    output logic                     g_wvalid,
    input  wire logic                g_wready,
    output axil_apb_pkg::data_t      g_wdata,
    output axil_apb_pkg::strb_t      g_wstrb,
    input  wire logic                g_bvalid,
    output logic                     g_bready,
    input  axil_apb_pkg::resp_t      g_bresp,
    output logic                     g_arvalid,
    input  wire logic                g_arready,
    output axil_apb_pkg::addr_t      g_araddr,
    output axil_apb_pkg::prot_t      g_arprot,
    input  wire logic                g_rvalid,
    output logic                     g_rready,
    input  axil_apb_pkg::data_t      g_rdata,
    input  axil_apb_pkg::resp_t      g_rresp
);

    localparam int unsigned CNT_W = $clog2(`AXIL_MAX_TRANS + 1);

    logic [CNT_W-1:0] out_cnt;
    logic [CNT_W-1:0] cnt_inc;
    logic [CNT_W-1:0] cnt_dec;
    logic             blocked;

    // New requests stop during a pause or when the counter is full.
    assign blocked = pause_req | (out_cnt == CNT_W'(`AXIL_MAX_TRANS));

    assign g_awvalid = s_awvalid & ~blocked;
    assign g_wvalid  = s_wvalid & ~blocked;
    assign g_arvalid = s_arvalid & ~blocked;
    assign s_awready = g_awready & ~blocked;
    assign s_wready  = g_wready & ~blocked;
    assign s_arready = g_arready & ~blocked;

    assign g_awaddr = s_awaddr;   // Payloads pass straight through.
    assign g_awprot = s_awprot;
    assign g_wdata  = s_wdata;
    assign g_wstrb  = s_wstrb;
    assign g_araddr = s_araddr;
    assign g_arprot = s_arprot;

    assign s_bvalid = g_bvalid;   // Responses are never held back.
    assign s_bresp  = g_bresp;
    assign g_bready = s_bready;
    assign s_rvalid = g_rvalid;
    assign s_rdata  = g_rdata;
    assign s_rresp  = g_rresp;
    assign g_rready = s_rready;

    assign cnt_inc = CNT_W'(g_awvalid & g_awready) + CNT_W'(g_arvalid & g_arready);
    assign cnt_dec = CNT_W'(g_bvalid & g_bready) + CNT_W'(g_rvalid & g_rready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_cnt   <= '0;
            pause_ack <= 1'b0;
        end else begin
            out_cnt   <= out_cnt + cnt_inc - cnt_dec;
            pause_ack <= pause_req && (out_cnt == '0);   // Idle and asked to pause.
        end
    end

endmodule

`default_nettype wire

//--- rtl/axil_apb_pkg.sv
`default_nettype none

`include "axil_apb_consts.svh"

package axil_apb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [2:0]                    prot_t;
    typedef logic [1:0]                    resp_t;
    typedef logic [`APB_NUM_SLAVES-1:0]    sel_t;   // One-hot completer select.

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // Bridge core FSM.
    typedef enum logic [2:0] {
        st_idle,
        st_setup,
        st_access,
        st_resp_write,
        st_resp_read
    } core_state_t;

endpackage

`default_nettype wire

//--- rtl/axil_apb_consts.svh
`ifndef AXIL_APB_CONSTS_SVH
`define AXIL_APB_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths and bridge sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define AXIL_ADDR_WIDTH 32   // AXI-Lite and APB address width.
`define AXIL_DATA_WIDTH 32   // Data word width, strobes are one per byte.
`define APB_NUM_SLAVES  2    // Number of APB completers.
`define AXIL_MAX_TRANS  4    // Outstanding limit in the pause gate.

`endif
